/* compile.f */
fpu_nc_pkg.sv
fp_classifier.sv
pipe_stage.sv
fpu_nc_ops.sv
fpu_nc_top.sv
fpu_nc_asserts.sv
tb_fpu_nc.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_fpu_nc -f compile.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_fpu_nc > sim.log 2>&1
cat sim.log
grep -q "SIMULATION PASSED" sim.log && echo "Run result: pass" \
  || { echo "Run result: fail"; exit 1; }

/* tb_fpu_nc.sv */
// Directed testbench for the binary32 non-computational FPU pipeline
`timescale 1ns/1ps

module tb_fpu_nc;

  localparam int          CLK_PERIOD   = 8;
  localparam int unsigned SEED         = 32'hea65dea9;
  // Item counts per test, they size the watchdog
  localparam int          SGNJ_ROUNDS  = 8;
  localparam int          SGNJ_ITEMS   = SGNJ_ROUNDS * 4;
  localparam int          MINMAX_ITEMS = 11;
  localparam int          CMP_ITEMS    = 8 * 6;
  localparam int          CLASS_ITEMS  = 10;
  localparam int          BP_ITEMS     = 5;
  localparam int          FLUSH_ITEMS  = 3;
  localparam int          TOTAL_ITEMS  = SGNJ_ITEMS + MINMAX_ITEMS + CMP_ITEMS + CLASS_ITEMS
                                         + BP_ITEMS + FLUSH_ITEMS;
  localparam int          WATCHDOG_CYCLES = TOTAL_ITEMS * 10;
  // Cycles with out_ready_i low in the back-pressure test
  localparam int          STALL_CYCLES = 6;

  // ----------------------------------------------------------------------
  // Binary32 operands
  // ----------------------------------------------------------------------
  localparam fpu_nc_pkg::fp_t P_ONE     = 32'h3f80_0000;
  localparam fpu_nc_pkg::fp_t P_TWO     = 32'h4000_0000;
  localparam fpu_nc_pkg::fp_t N_ONE     = 32'hbf80_0000;
  localparam fpu_nc_pkg::fp_t N_TWO     = 32'hc000_0000;
  localparam fpu_nc_pkg::fp_t P_ZERO    = 32'h0000_0000;
  localparam fpu_nc_pkg::fp_t N_ZERO    = 32'h8000_0000;
  // Quiet NaNs with payloads, so a canonical result stands out
  localparam fpu_nc_pkg::fp_t Q_NAN     = 32'h7fc1_2345;
  localparam fpu_nc_pkg::fp_t NQ_NAN    = 32'hffc0_0001;
  localparam fpu_nc_pkg::fp_t S_NAN     = 32'h7f80_0001;
  localparam fpu_nc_pkg::fp_t CANON_NAN = 32'h7fc0_0000;

  logic                clk_i;
  logic                rst_n_i;
  logic                flush_i;
  logic                in_valid_i;
  logic                in_ready_o;
  fpu_nc_pkg::nc_req_t req_i;
  logic                out_valid_o;
  logic                out_ready_i;
  fpu_nc_pkg::nc_rsp_t rsp_o;
  logic                busy_o;

  int                  errors;
  int                  checks;
  int                  tests;
  int unsigned         seed_ret;
  fpu_nc_pkg::tag_t    next_tag;

  fpu_nc_top dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .req_i       (req_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rsp_o       (rsp_o),
    .busy_o      (busy_o)
  );

  bind fpu_nc_top fpu_nc_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .rsp_i       (rsp_o),
    .busy_i      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // Compare tasks, one per result type
  // ----------------------------------------------------------------------
  task automatic check_fp(input string name, input fpu_nc_pkg::fp_t got,
                          input fpu_nc_pkg::fp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input fpu_nc_pkg::status_t got,
                              input fpu_nc_pkg::status_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_class(input string name, input fpu_nc_pkg::classmask_e got,
                             input fpu_nc_pkg::classmask_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_tag(input string name, input fpu_nc_pkg::tag_t got,
                           input fpu_nc_pkg::tag_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  // ----------------------------------------------------------------------
  // Driver helpers
  // ----------------------------------------------------------------------
  function automatic fpu_nc_pkg::nc_req_t make_req(input fpu_nc_pkg::fp_t a,
                                                   input fpu_nc_pkg::fp_t b,
                                                   input fpu_nc_pkg::operation_e op,
                                                   input fpu_nc_pkg::roundmode_e mode,
                                                   input logic op_mod);
    fpu_nc_pkg::nc_req_t req;
    req           = '0;
    req.operand_a = a;
    req.operand_b = b;
    req.op        = op;
    req.rnd_mode  = mode;
    req.op_mod    = op_mod;
    return req;
  endfunction

  // Send one request with out_ready_i high, wait for its response
  // Entered and left just after a falling edge
  task automatic exec_item(input fpu_nc_pkg::nc_req_t req, output fpu_nc_pkg::nc_rsp_t rsp);
    fpu_nc_pkg::tag_t tag;
    int               cyc;
    int               accept_cyc;
    int               done_cyc;
    logic             accepted;
    logic             taken;
    logic             done;
    tag        = next_tag;
    next_tag   = next_tag + 1'b1;
    req.tag    = tag;
    cyc        = 0;
    accept_cyc = 0;
    done_cyc   = 0;
    accepted   = 1'b0;
    done       = 1'b0;
    rsp        = '0;
    req_i      = req;
    in_valid_i = 1'b1;
    while (!done) begin
      // Sample after the inputs have settled
      #1;
      taken = in_valid_i & in_ready_o;
      if (accepted && out_valid_o) begin
        rsp      = rsp_o;
        done     = 1'b1;
        done_cyc = cyc;
      end
      @(negedge clk_i);
      if (taken) begin
        in_valid_i = 1'b0;
        accepted   = 1'b1;
        accept_cyc = cyc;
      end
      cyc++;
    end
    check_tag("rsp_o.tag", rsp.tag, tag);
    checks++;
    if (done_cyc - accept_cyc != 2) begin
      errors++;
      $display("Response for tag %0d came %0d cycles after acceptance instead of 2",
               tag, done_cyc - accept_cyc);
    end
  endtask

  task automatic check_rsp(input fpu_nc_pkg::nc_rsp_t rsp, input fpu_nc_pkg::fp_t result,
                           input fpu_nc_pkg::status_t status, input logic is_class);
    check_fp("rsp_o.result", rsp.result, result);
    check_status("rsp_o.status", rsp.status, status);
    check_bit("rsp_o.is_class", rsp.is_class, is_class);
  endtask

  task automatic end_test(input string name, input int err_start);
    tests++;
    $display("Test %-14s %s", name, (errors == err_start) ? "ok" : "had errors");
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset();
    int err_start;
    err_start = errors;
    #1;
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    @(negedge clk_i);
    end_test("reset", err_start);
  endtask

  task automatic test_sign_inject();
    fpu_nc_pkg::fp_t        a;
    fpu_nc_pkg::fp_t        b;
    fpu_nc_pkg::fp_t        exp;
    fpu_nc_pkg::roundmode_e mode;
    fpu_nc_pkg::nc_rsp_t    rsp;
    logic [31:0]            rnd;
    int                     err_start;
    err_start = errors;
    for (int r = 0; r < SGNJ_ROUNDS; r++) begin
      a   = $urandom();
      b   = $urandom();
      rnd = $urandom();
      for (int m = 0; m < 4; m++) begin
        mode = fpu_nc_pkg::roundmode_e'(3'(m));
        // Magnitude of a with a sign picked per sub-operation
        exp = a;
        case (mode)
          fpu_nc_pkg::RNE: exp.sign = b.sign;
          fpu_nc_pkg::RTZ: exp.sign = ~b.sign;
          fpu_nc_pkg::RDN: exp.sign = a.sign ^ b.sign;
          default:         exp.sign = a.sign;
        endcase
        exec_item(make_req(a, b, fpu_nc_pkg::SGNJ, mode, rnd[m]), rsp);
        check_rsp(rsp, exp, '0, 1'b0);
      end
    end
    end_test("sign_inject", err_start);
  endtask

  task automatic run_minmax(input fpu_nc_pkg::fp_t a, input fpu_nc_pkg::fp_t b,
                            input fpu_nc_pkg::roundmode_e mode,
                            input fpu_nc_pkg::fp_t exp, input logic nv);
    fpu_nc_pkg::nc_rsp_t rsp;
    fpu_nc_pkg::status_t st;
    st    = '0;
    st.nv = nv;
    exec_item(make_req(a, b, fpu_nc_pkg::MINMAX, mode, 1'b0), rsp);
    check_rsp(rsp, exp, st, 1'b0);
  endtask

  task automatic test_min_max();
    int err_start;
    err_start = errors;
    // RNE selects the minimum, RTZ the maximum
    run_minmax(P_ONE, P_TWO, fpu_nc_pkg::RNE, P_ONE, 1'b0);
    run_minmax(P_ONE, P_TWO, fpu_nc_pkg::RTZ, P_TWO, 1'b0);
    run_minmax(N_ONE, N_TWO, fpu_nc_pkg::RNE, N_TWO, 1'b0);
    run_minmax(N_ONE, P_TWO, fpu_nc_pkg::RTZ, P_TWO, 1'b0);
    run_minmax(P_ZERO, N_ZERO, fpu_nc_pkg::RNE, N_ZERO, 1'b0);
    run_minmax(N_ZERO, P_ZERO, fpu_nc_pkg::RTZ, P_ZERO, 1'b0);
    // A single NaN yields the other operand
    run_minmax(Q_NAN, P_TWO, fpu_nc_pkg::RNE, P_TWO, 1'b0);
    run_minmax(P_ONE, Q_NAN, fpu_nc_pkg::RTZ, P_ONE, 1'b0);
    run_minmax(Q_NAN, NQ_NAN, fpu_nc_pkg::RNE, CANON_NAN, 1'b0);
    run_minmax(S_NAN, P_ONE, fpu_nc_pkg::RNE, P_ONE, 1'b1);
    run_minmax(S_NAN, Q_NAN, fpu_nc_pkg::RTZ, CANON_NAN, 1'b1);
    end_test("min_max", err_start);
  endtask

  // LE, LT and EQ with and without inversion for one operand pair
  task automatic cmp_pair(input fpu_nc_pkg::fp_t a, input fpu_nc_pkg::fp_t b,
                          input logic lt, input logic eq, input logic unord, input logic snan);
    fpu_nc_pkg::nc_rsp_t    rsp;
    fpu_nc_pkg::roundmode_e mode;
    fpu_nc_pkg::status_t    st;
    fpu_nc_pkg::fp_t        exp;
    logic                   mod;
    logic                   res;
    for (int op = 0; op < 3; op++) begin
      for (int m = 0; m < 2; m++) begin
        mod = m[0];
        st  = '0;
        case (op)
          0: begin
            mode  = fpu_nc_pkg::RNE;
            res   = unord ? 1'b0 : ((lt | eq) ^ mod);
            st.nv = unord;
          end
          1: begin
            mode  = fpu_nc_pkg::RTZ;
            res   = unord ? 1'b0 : (lt ^ mod);
            st.nv = unord;
          end
          default: begin
            // Quiet equality, inverted unordered gives one
            mode  = fpu_nc_pkg::RDN;
            res   = unord ? mod : (eq ^ mod);
            st.nv = snan;
          end
        endcase
        exp             = '0;
        exp.mantissa[0] = res;
        exec_item(make_req(a, b, fpu_nc_pkg::CMP, mode, mod), rsp);
        check_rsp(rsp, exp, st, 1'b0);
      end
    end
  endtask

  task automatic test_compare();
    int err_start;
    err_start = errors;
    cmp_pair(P_ONE, P_TWO, 1'b1, 1'b0, 1'b0, 1'b0);
    cmp_pair(P_TWO, P_ONE, 1'b0, 1'b0, 1'b0, 1'b0);
    cmp_pair(N_TWO, N_ONE, 1'b1, 1'b0, 1'b0, 1'b0);
    cmp_pair(P_ONE, P_ONE, 1'b0, 1'b1, 1'b0, 1'b0);
    cmp_pair(P_ZERO, N_ZERO, 1'b0, 1'b1, 1'b0, 1'b0);
    cmp_pair(N_ZERO, P_ZERO, 1'b0, 1'b1, 1'b0, 1'b0);
    cmp_pair(Q_NAN, P_ONE, 1'b0, 1'b0, 1'b1, 1'b0);
    cmp_pair(P_ONE, S_NAN, 1'b0, 1'b0, 1'b1, 1'b1);
    end_test("compare", err_start);
  endtask

  task automatic test_classify();
    fpu_nc_pkg::fp_t        vals[CLASS_ITEMS];
    fpu_nc_pkg::classmask_e masks[CLASS_ITEMS];
    fpu_nc_pkg::fp_t        b;
    fpu_nc_pkg::nc_rsp_t    rsp;
    int                     err_start;
    err_start = errors;
    vals  = '{32'hff80_0000, 32'hbf80_0000, 32'h807f_ffff, 32'h8000_0000, 32'h0000_0000,
              32'h0000_0001, 32'h3f80_0000, 32'h7f80_0000, 32'h7fa0_0000, 32'h7fc0_0000};
    masks = '{fpu_nc_pkg::NEGINF, fpu_nc_pkg::NEGNORM, fpu_nc_pkg::NEGSUBNORM,
              fpu_nc_pkg::NEGZERO, fpu_nc_pkg::POSZERO, fpu_nc_pkg::POSSUBNORM,
              fpu_nc_pkg::POSNORM, fpu_nc_pkg::POSINF, fpu_nc_pkg::SNAN, fpu_nc_pkg::QNAN};
    for (int i = 0; i < CLASS_ITEMS; i++) begin
      // Operand b must not matter
      b = $urandom();
      exec_item(make_req(vals[i], b, fpu_nc_pkg::CLASSIFY, fpu_nc_pkg::RNE, 1'b0), rsp);
      check_class("rsp_o.class_mask", rsp.class_mask, masks[i]);
      check_rsp(rsp, '0, '0, 1'b1);
    end
    end_test("classify", err_start);
  endtask

  task automatic test_backpressure();
    fpu_nc_pkg::fp_t     vals[BP_ITEMS];
    fpu_nc_pkg::tag_t    tags[BP_ITEMS];
    fpu_nc_pkg::nc_req_t req;
    int                  n_in;
    int                  n_out;
    int                  cyc;
    int                  err_start;
    logic                take_in;
    logic                take_out;
    err_start = errors;
    for (int i = 0; i < BP_ITEMS; i++) begin
      vals[i]  = $urandom();
      tags[i]  = next_tag;
      next_tag = next_tag + 1'b1;
    end
    n_in        = 0;
    n_out       = 0;
    cyc         = 0;
    out_ready_i = 1'b0;
    // Passthrough items, result equals operand a
    req         = make_req(vals[0], vals[0], fpu_nc_pkg::SGNJ, fpu_nc_pkg::RUP, 1'b0);
    req.tag     = tags[0];
    req_i       = req;
    in_valid_i  = 1'b1;
    while (n_out < BP_ITEMS) begin
      #1;
      take_in  = in_valid_i & in_ready_o;
      take_out = out_valid_o & out_ready_i;
      // Two items fill both stages
      if (!out_ready_i && n_in >= 2) begin
        check_bit("in_ready_o", in_ready_o, 1'b0);
      end
      if (take_out) begin
        check_fp("rsp_o.result", rsp_o.result, vals[n_out]);
        check_tag("rsp_o.tag", rsp_o.tag, tags[n_out]);
        n_out++;
      end
      @(negedge clk_i);
      if (take_in) begin
        n_in++;
        if (n_in < BP_ITEMS) begin
          req     = make_req(vals[n_in], vals[n_in], fpu_nc_pkg::SGNJ, fpu_nc_pkg::RUP, 1'b0);
          req.tag = tags[n_in];
          req_i   = req;
        end else begin
          in_valid_i = 1'b0;
        end
      end
      cyc++;
      if (cyc == STALL_CYCLES) begin
        checks++;
        if (n_in != 2) begin
          errors++;
          $display("Stalled pipeline took %0d items instead of 2", n_in);
        end
        out_ready_i = 1'b1;
      end
    end
    end_test("backpressure", err_start);
  endtask

  task automatic test_flush();
    fpu_nc_pkg::nc_rsp_t rsp;
    int                  err_start;
    err_start   = errors;
    out_ready_i = 1'b0;
    req_i       = make_req(P_TWO, P_ONE, fpu_nc_pkg::MINMAX, fpu_nc_pkg::RTZ, 1'b0);
    in_valid_i  = 1'b1;
    @(negedge clk_i);
    req_i.tag   = req_i.tag + 1'b1;
    @(negedge clk_i);
    in_valid_i  = 1'b0;
    #1;
    check_bit("busy_o", busy_o, 1'b1);
    check_bit("out_valid_o", out_valid_o, 1'b1);
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    #1;
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    @(negedge clk_i);
    out_ready_i = 1'b1;
    // Pipeline still works after the flush
    exec_item(make_req(P_ONE, P_TWO, fpu_nc_pkg::MINMAX, fpu_nc_pkg::RNE, 1'b0), rsp);
    check_rsp(rsp, P_ONE, '0, 1'b0);
    end_test("flush", err_start);
  endtask

  // ----------------------------------------------------------------------
  // Watchdog and main sequence
  // ----------------------------------------------------------------------
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a test is stuck", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int total_errors;
    seed_ret    = $urandom(SEED);
    errors      = 0;
    checks      = 0;
    tests       = 0;
    next_tag    = '0;
    rst_n_i     = 1'b0;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    req_i       = '0;
    out_ready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    test_reset();
    test_sign_inject();
    test_min_max();
    test_compare();
    test_classify();
    test_backpressure();
    test_flush();

    total_errors = errors + dut.u_asserts.fail_count;
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, dut.u_asserts.fail_count);
    if (total_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* fpu_nc_asserts.sv */
// Concurrent checks on the FPU pipeline for reset, stall and flush behaviour
`timescale 1ns/1ps

module fpu_nc_asserts (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                flush_i,
  input logic                out_valid_i,
  input logic                out_ready_i,
  input fpu_nc_pkg::nc_rsp_t rsp_i,
  input logic                busy_i
);

  // Count of failed assertions, summed by the testbench
  int fail_count = 0;

  // Synchronous reset empties every stage
  reset_empty: assert property (@(posedge clk_i) !rst_n_i |=> !out_valid_i && !busy_i)
    else begin
      $error("Output valid or busy high after a reset cycle");
      fail_count++;
    end

  // A stalled response stays put
  stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_i && !out_ready_i && !flush_i |=> out_valid_i && $stable(rsp_i))
    else begin
      $error("Stalled response changed or was dropped");
      fail_count++;
    end

  // Flush leaves nothing in flight
  flush_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_i && !busy_i)
    else begin
      $error("Item still valid after a flush");
      fail_count++;
    end

endmodule

/* fpu_nc_top.sv */
// Non-computational FPU top: input stages, operation block, output stages
`timescale 1ns/1ps

module fpu_nc_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                flush_i,
  // Request side
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  fpu_nc_pkg::nc_req_t req_i,
  // Response side
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output fpu_nc_pkg::nc_rsp_t rsp_o,
  // High while any stage holds an item
  output logic                busy_o
);

  localparam int unsigned NI = fpu_nc_pkg::NUM_INP_REGS;
  localparam int unsigned NO = fpu_nc_pkg::NUM_OUT_REGS;

  // ----------------------------------------------------------------------
  // Input chain, index i is the signal after i stages
  // ----------------------------------------------------------------------
  logic                [0:NI] inp_valid;
  logic                [0:NI] inp_ready;
  fpu_nc_pkg::nc_req_t [0:NI] inp_data;

  assign inp_valid[0] = in_valid_i;
  assign inp_data[0]  = req_i;
  assign in_ready_o   = inp_ready[0];

  for (genvar i = 0; i < NI; i++) begin : gen_inp_stage
    pipe_stage #(
      .payload_t (fpu_nc_pkg::nc_req_t)
    ) u_stage (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .flush_i (flush_i),
      .valid_i (inp_valid[i]),
      .ready_o (inp_ready[i]),
      .data_i  (inp_data[i]),
      .valid_o (inp_valid[i+1]),
      .ready_i (inp_ready[i+1]),
      .data_o  (inp_data[i+1])
    );
  end

  // ----------------------------------------------------------------------
  // Operation block, handshake passes straight across
  // ----------------------------------------------------------------------
  logic                [0:NO] out_valid;
  logic                [0:NO] out_ready;
  fpu_nc_pkg::nc_rsp_t [0:NO] out_data;

  fpu_nc_ops u_ops (
    .req_i (inp_data[NI]),
    .rsp_o (out_data[0])
  );

  assign out_valid[0]  = inp_valid[NI];
  assign inp_ready[NI] = out_ready[0];

  // Output chain
  for (genvar i = 0; i < NO; i++) begin : gen_out_stage
    pipe_stage #(
      .payload_t (fpu_nc_pkg::nc_rsp_t)
    ) u_stage (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .flush_i (flush_i),
      .valid_i (out_valid[i]),
      .ready_o (out_ready[i]),
      .data_i  (out_data[i]),
      .valid_o (out_valid[i+1]),
      .ready_i (out_ready[i+1]),
      .data_o  (out_data[i+1])
    );
  end

  assign out_ready[NO] = out_ready_i;
  assign out_valid_o   = out_valid[NO];
  assign rsp_o         = out_data[NO];

  // Registered valids only, the raw request does not count
  assign busy_o = |{inp_valid[1:NI], out_valid[1:NO]};

endmodule

/* fpu_nc_ops.sv */
// Combinational datapath for sign injection, min/max, compare and classify
`timescale 1ns/1ps

module fpu_nc_ops (
  input  fpu_nc_pkg::nc_req_t req_i,
  output fpu_nc_pkg::nc_rsp_t rsp_o
);

  fpu_nc_pkg::fp_t      op_a;
  fpu_nc_pkg::fp_t      op_b;
  fpu_nc_pkg::fp_info_t info_a;
  fpu_nc_pkg::fp_info_t info_b;

  assign op_a = req_i.operand_a;
  assign op_b = req_i.operand_b;

  // One classifier per operand
  fp_classifier u_class_a (
    .operand_i (op_a),
    .info_o    (info_a)
  );

  fp_classifier u_class_b (
    .operand_i (op_b),
    .info_o    (info_b)
  );

  // ----------------------------------------------------------------------
  // Shared compare terms
  // ----------------------------------------------------------------------
  logic any_nan;
  logic any_snan;
  logic equal;
  logic a_smaller;

  assign any_nan  = info_a.is_nan | info_b.is_nan;
  assign any_snan = info_a.is_signalling | info_b.is_signalling;
  // Both zeros are equal regardless of sign
  assign equal    = (op_a == op_b) | (info_a.is_zero & info_b.is_zero);

  // Sign-aware ordering; -0 sorts below +0
  always_comb begin
    if (op_a.sign != op_b.sign) begin
      a_smaller = op_a.sign;
    end else if (op_a.sign) begin
      // Both negative, larger magnitude is smaller
      a_smaller = {op_a.exponent, op_a.mantissa} > {op_b.exponent, op_b.mantissa};
    end else begin
      a_smaller = {op_a.exponent, op_a.mantissa} < {op_b.exponent, op_b.mantissa};
    end
  end

  // ----------------------------------------------------------------------
  // Sign injection
  // ----------------------------------------------------------------------
  fpu_nc_pkg::fp_t sgnj_result;

  // RNE copies, RTZ negates, RDN xors b's sign; RUP passes a through
  always_comb begin
    sgnj_result = op_a;
    case (req_i.rnd_mode)
      fpu_nc_pkg::RNE: sgnj_result.sign = op_b.sign;
      fpu_nc_pkg::RTZ: sgnj_result.sign = ~op_b.sign;
      fpu_nc_pkg::RDN: sgnj_result.sign = op_a.sign ^ op_b.sign;
      default:         sgnj_result      = op_a;
    endcase
  end

  // ----------------------------------------------------------------------
  // Minimum / maximum
  // ----------------------------------------------------------------------
  fpu_nc_pkg::fp_t minmax_result;

  // RNE picks the minimum, any other mode the maximum
  always_comb begin
    if (info_a.is_nan && info_b.is_nan) begin
      minmax_result = fpu_nc_pkg::CANON_QNAN;
    end else if (info_a.is_nan) begin
      minmax_result = op_b;
    end else if (info_b.is_nan) begin
      minmax_result = op_a;
    end else if (req_i.rnd_mode == fpu_nc_pkg::RNE) begin
      minmax_result = a_smaller ? op_a : op_b;
    end else begin
      minmax_result = a_smaller ? op_b : op_a;
    end
  end

  // ----------------------------------------------------------------------
  // Comparisons
  // ----------------------------------------------------------------------
  logic cmp_bit;
  logic cmp_nv;

  // RNE = LE and RTZ = LT signal on any NaN; RDN = EQ is quiet
  always_comb begin
    cmp_bit = 1'b0;
    cmp_nv  = 1'b0;
    case (req_i.rnd_mode)
      fpu_nc_pkg::RNE: begin
        cmp_nv  = any_nan;
        cmp_bit = ~any_nan & ((a_smaller | equal) ^ req_i.op_mod);
      end
      fpu_nc_pkg::RTZ: begin
        cmp_nv  = any_nan;
        cmp_bit = ~any_nan & ((a_smaller & ~equal) ^ req_i.op_mod);
      end
      fpu_nc_pkg::RDN: begin
        cmp_nv  = any_snan;
        // Unordered never equals, so inversion yields one
        cmp_bit = any_nan ? req_i.op_mod : (equal ^ req_i.op_mod);
      end
      default: begin
        cmp_bit = 1'b0;
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // Classification of operand a
  // ----------------------------------------------------------------------
  fpu_nc_pkg::classmask_e class_mask;

  always_comb begin
    if (info_a.is_normal) begin
      class_mask = op_a.sign ? fpu_nc_pkg::NEGNORM : fpu_nc_pkg::POSNORM;
    end else if (info_a.is_subnormal) begin
      class_mask = op_a.sign ? fpu_nc_pkg::NEGSUBNORM : fpu_nc_pkg::POSSUBNORM;
    end else if (info_a.is_zero) begin
      class_mask = op_a.sign ? fpu_nc_pkg::NEGZERO : fpu_nc_pkg::POSZERO;
    end else if (info_a.is_inf) begin
      class_mask = op_a.sign ? fpu_nc_pkg::NEGINF : fpu_nc_pkg::POSINF;
    end else begin
      class_mask = info_a.is_quiet ? fpu_nc_pkg::QNAN : fpu_nc_pkg::SNAN;
    end
  end

  // ----------------------------------------------------------------------
  // Result selection
  // ----------------------------------------------------------------------
  always_comb begin
    rsp_o            = '0;
    rsp_o.class_mask = class_mask;
    rsp_o.tag        = req_i.tag;
    case (req_i.op)
      fpu_nc_pkg::SGNJ:   rsp_o.result = sgnj_result;
      fpu_nc_pkg::MINMAX: begin
        rsp_o.result    = minmax_result;
        // Quiet comparison, only sNaN is invalid
        rsp_o.status.nv = any_snan;
      end
      fpu_nc_pkg::CMP: begin
        rsp_o.result    = {{(fpu_nc_pkg::FP_WIDTH-1){1'b0}}, cmp_bit};
        rsp_o.status.nv = cmp_nv;
      end
      default:            rsp_o.is_class = 1'b1;
    endcase
  end

endmodule

/* pipe_stage.sv */
// Single valid/ready register stage with synchronous flush and typed payload
`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Accept when the next stage takes our item or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;

  // ----------------------------------------------------------------------
  // Valid bit, cleared by reset and flush
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on a real transfer
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* fp_classifier.sv */
// Binary32 operand classifier: zero, subnormal, normal, infinity and NaN kinds
`timescale 1ns/1ps

module fp_classifier (
  input  fpu_nc_pkg::fp_t      operand_i,
  output fpu_nc_pkg::fp_info_t info_o
);

  logic exp_ones;
  logic exp_zero;
  logic man_zero;
  logic quiet_bit;

  // Field decode
  assign exp_ones  = &operand_i.exponent;
  assign exp_zero  = ~|operand_i.exponent;
  assign man_zero  = ~|operand_i.mantissa;
  // Top mantissa bit tells quiet from signalling NaNs
  assign quiet_bit = operand_i.mantissa[fpu_nc_pkg::MAN_BITS-1];

  // ----------------------------------------------------------------------
  // Class flags
  // ----------------------------------------------------------------------
  always_comb begin
    info_o = '0;
    // Biased exponent strictly between the extremes
    info_o.is_normal     = ~exp_ones & ~exp_zero;
    // Zero exponent splits on the mantissa
    info_o.is_subnormal  = exp_zero & ~man_zero;
    info_o.is_zero       = exp_zero & man_zero;
    // All-ones exponent, same split
    info_o.is_inf        = exp_ones & man_zero;
    info_o.is_nan        = exp_ones & ~man_zero;
    // NaN kind
    info_o.is_signalling = exp_ones & ~man_zero & ~quiet_bit;
    info_o.is_quiet      = exp_ones & quiet_bit;
  end

endmodule

/* fpu_nc_pkg.sv */
// Shared types and constants for the binary32 non-computational FPU
package fpu_nc_pkg;

  // ----------------------------------------------------------------------
  // Format and pipeline constants
  // ----------------------------------------------------------------------
  localparam int unsigned FP_WIDTH     = 32;
  localparam int unsigned EXP_BITS     = 8;
  localparam int unsigned MAN_BITS     = 23;
  localparam int unsigned TAG_WIDTH    = 4;
  // Register stages before and after the operation block
  localparam int unsigned NUM_INP_REGS = 1;
  localparam int unsigned NUM_OUT_REGS = 1;

  // Binary32 value split into its fields
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  // Canonical quiet NaN: positive, exponent all ones, top mantissa bit set
  localparam fp_t CANON_QNAN = {1'b0, {EXP_BITS{1'b1}}, 1'b1, {(MAN_BITS-1){1'b0}}};

  // Operation group
  typedef enum logic [1:0] {
    SGNJ     = 2'd0,
    MINMAX   = 2'd1,
    CMP      = 2'd2,
    CLASSIFY = 2'd3
  } operation_e;

  // Sub-operation selector, reuses the rounding-mode encoding
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011
  } roundmode_e;

  // IEEE exception flags, invalid first
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // One-hot class mask in fclass bit order
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

  // Per-operand class flags
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  typedef logic [TAG_WIDTH-1:0] tag_t;

  // ----------------------------------------------------------------------
  // Request and response payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    fp_t        operand_a;
    fp_t        operand_b;
    operation_e op;
    roundmode_e rnd_mode;
    logic       op_mod;
    tag_t       tag;
  } nc_req_t;

  typedef struct packed {
    fp_t        result;
    status_t    status;
    classmask_e class_mask;
    logic       is_class;
    tag_t       tag;
  } nc_rsp_t;

endpackage
